// ==== build.f ====
hdl/cpuPkg.sv
hdl/instFetch.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/dataMem.sv
hdl/cpuTop.sv
test/cpuTb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire clk,
	input wire reset,
	input wire valid,
	input wire cpuPkg::decodedT decoded,
	input wire [15:0] operandA,
	input wire [15:0] operandB,
	output logic [15:0] result,
	output cpuPkg::flagsT flags
);

	logic [15:0] opB;
	// 17 bits so bit 16 holds carry out or borrow
	logic [16:0] wide;
	logic updateFlags;
	cpuPkg::flagsT flagsNext;

	// operand b select
	assign opB = decoded.selectImm ? decoded.imm : operandB;

	always_comb begin
		wide = '0;
		updateFlags = 1'b0;
		result = '0;
		case (decoded.op)
			cpuPkg::aluAdd, cpuPkg::aluAddu: begin
				wide = {1'b0, operandA} + {1'b0, opB};
				result = wide[15:0];
				updateFlags = 1'b1;
			end
			cpuPkg::aluAddc, cpuPkg::aluAddcu: begin
				// carry in from the previous add
				wide = {1'b0, operandA} + {1'b0, opB} + {16'h0000, flags.carry};
				result = wide[15:0];
				updateFlags = 1'b1;
			end
			cpuPkg::aluSub, cpuPkg::aluCmp: begin
				// bit 16 set when a < b
				wide = {1'b0, operandA} - {1'b0, opB};
				result = wide[15:0];
				updateFlags = 1'b1;
			end
			cpuPkg::aluAnd: result = operandA & opB;
			cpuPkg::aluOr: result = operandA | opB;
			cpuPkg::aluXor: result = operandA ^ opB;
			cpuPkg::aluNot: result = ~opB;
			cpuPkg::aluMov: result = opB;
			cpuPkg::aluMovi, cpuPkg::aluLui: result = decoded.imm;
			// shift amount is always b[3:0]
			cpuPkg::aluLsh, cpuPkg::aluAlsh: result = operandA << opB[3:0];
			cpuPkg::aluRsh: result = operandA >> opB[3:0];
			cpuPkg::aluArsh: result = $signed(operandA) >>> opB[3:0];
			default: result = '0;
		endcase
	end

	assign flagsNext = '{carry: wide[16], zero: (result == 16'h0000), negative: result[15]};

	// flags move only on executed add, sub and cmp
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (valid && updateFlags) begin
			flags <= flagsNext;
		end
	end

	// a decoded word either stores or writes back, never both
	assert property (@(posedge clk) disable iff (reset)
		valid |-> !(decoded.storeWe && decoded.regWrite))
		else $error("store and register writeback decoded together");

endmodule

`default_nettype wire

// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	////////////////////////////////////////////////////////////////////////////
	// operation and major codes
	////////////////////////////////////////////////////////////////////////////

	// each value is {major, minor} as encoded in the instruction word
	typedef enum logic [7:0] {
		aluAnd   = 8'h01,
		aluOr    = 8'h02,
		aluXor   = 8'h03,
		aluAddcu = 8'h04,
		aluAdd   = 8'h05,
		aluAddu  = 8'h06,
		aluAddc  = 8'h07,
		aluSub   = 8'h09,
		aluCmp   = 8'h0b,
		aluMov   = 8'h0d,
		aluNot   = 8'h0f,
		aluLsh   = 8'h84,
		aluAlsh  = 8'h85,
		aluRsh   = 8'h8c,
		aluArsh  = 8'h8d,
		// immediate-only results
		aluMovi  = 8'hd0,
		aluLui   = 8'hf0
	} aluOpE;

	// bits 15..12 of a word with top bits 00
	typedef enum logic [3:0] {
		majRtype  = 4'h0,
		majMem    = 4'h4,
		majAddi   = 4'h5,
		majAddui  = 4'h6,
		majAddci  = 4'h7,
		majShift  = 4'h8,
		majSubi   = 4'h9,
		majAddcui = 4'ha,
		majCmpi   = 4'hb,
		majMovi   = 4'hd,
		majCmpui  = 4'he,
		majLui    = 4'hf
	} majorE;

	////////////////////////////////////////////////////////////////////////////
	// datapath bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		aluOpE       op;
		logic [15:0] imm;
		logic        selectImm;
		// load result comes from data memory
		logic        selectResult;
		logic        storeWe;
		logic        regWrite;
		logic [3:0]  memAddr;
		logic [3:0]  readRegA;
		logic [3:0]  readRegB;
		logic [3:0]  loadReg;
	} decodedT;

	typedef struct packed {
		logic carry;
		logic zero;
		logic negative;
	} flagsT;

	typedef struct packed {
		logic        valid;
		logic [17:0] inst;
	} fetchT;

endpackage

`default_nettype wire

// ==== hdl/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
	parameter int progDepth = 64
) (
	input wire clk,
	input wire reset,
	input wire run,
	input wire progWe,
	input wire [$clog2(progDepth)-1:0] progAddr,
	input wire [17:0] progData,
	output logic wbValid,
	output logic [3:0] wbReg,
	output logic [15:0] wbData,
	output logic storeWe,
	output logic [3:0] storeAddr,
	output logic [15:0] storeData,
	output cpuPkg::flagsT flags
);

	cpuPkg::fetchT fetched;
	cpuPkg::decodedT decoded;
	logic [15:0] readDataA;
	logic [15:0] readDataB;
	logic [15:0] aluResult;
	logic [15:0] loadData;

	////////////////////////////////////////////////////////////////////////////
	// fetch and decode
	////////////////////////////////////////////////////////////////////////////

	instFetch #(.progDepth(progDepth)) fetch0 (
		.clk(clk), .reset(reset), .run(run), .progWe(progWe),
		.progAddr(progAddr), .progData(progData), .fetched(fetched)
	);

	decoder decode0 (.inst(fetched.inst), .decoded(decoded));

	////////////////////////////////////////////////////////////////////////////
	// execute and writeback, all in one cycle
	////////////////////////////////////////////////////////////////////////////

	assign wbValid = fetched.valid & decoded.regWrite;
	assign wbReg = decoded.loadReg;
	// load data or alu result into the register file
	assign wbData = decoded.selectResult ? loadData : aluResult;

	regFile regs0 (
		.clk(clk), .reset(reset), .writeEn(wbValid), .writeReg(wbReg), .writeData(wbData),
		.readRegA(decoded.readRegA), .readRegB(decoded.readRegB),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	alu alu0 (
		.clk(clk), .reset(reset), .valid(fetched.valid), .decoded(decoded),
		.operandA(readDataA), .operandB(readDataB), .result(aluResult), .flags(flags)
	);

	// store data is the register on port a
	assign storeWe = fetched.valid & decoded.storeWe;
	assign storeAddr = decoded.memAddr;
	assign storeData = readDataA;

	dataMem mem0 (
		.clk(clk), .reset(reset), .storeEn(storeWe), .addr(storeAddr),
		.storeData(storeData), .loadData(loadData)
	);

endmodule

`default_nettype wire

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem (
	input wire clk,
	input wire reset,
	input wire storeEn,
	input wire [3:0] addr,
	input wire [15:0] storeData,
	output logic [15:0] loadData
);

	logic [15:0] mem [16];

	// store on the edge, whole memory clears on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				mem[i] <= '0;
			end
		end else if (storeEn) begin
			mem[addr] <= storeData;
		end
	end

	// asynchronous read for load
	assign loadData = mem[addr];

	// store address settled and known for the whole store cycle
	assert property (@(posedge clk) disable iff (reset) storeEn |-> !$isunknown(addr))
		else $error("store address not stable during store");

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input wire [17:0] inst,
	output cpuPkg::decodedT decoded
);

	// minor codes that have no operation of their own
	localparam logic [3:0] lshiMinor = 4'h0;
	localparam logic [3:0] rshiMinor = 4'h1;
	localparam logic [3:0] loadMinor = 4'h0;
	localparam logic [3:0] storMinor = 4'h4;

	cpuPkg::majorE major;
	cpuPkg::aluOpE minorOp;
	logic [15:0] signImm;
	logic [15:0] zeroImm;

	assign major = cpuPkg::majorE'(inst[15:12]);
	// r-type and shift ops carry their full code in {major, minor}
	assign minorOp = cpuPkg::aluOpE'({inst[15:12], inst[7:4]});
	assign signImm = {{8{inst[7]}}, inst[7:0]};
	assign zeroImm = {8'h00, inst[7:0]};

	always_comb begin
		// no-op unless a case below says otherwise
		decoded = '0;
		decoded.op = cpuPkg::aluOr;
		decoded.readRegA = inst[11:8];
		decoded.readRegB = inst[3:0];
		decoded.loadReg = inst[11:8];
		decoded.memAddr = inst[3:0];
		if (inst[17:16] == 2'b11) begin
			// full 16-bit load, dest field shares imm bits 11..8
			decoded.op = cpuPkg::aluLui;
			decoded.imm = inst[15:0];
			decoded.selectImm = 1'b1;
			decoded.regWrite = 1'b1;
		end else if (inst[17:16] == 2'b00) begin
			case (major)
				cpuPkg::majRtype: begin
					case (minorOp)
						cpuPkg::aluAdd, cpuPkg::aluAddu, cpuPkg::aluAddc, cpuPkg::aluAddcu,
						cpuPkg::aluSub, cpuPkg::aluAnd, cpuPkg::aluOr, cpuPkg::aluXor,
						cpuPkg::aluNot: begin
							decoded.op = minorOp;
							decoded.regWrite = 1'b1;
						end
						cpuPkg::aluCmp: begin
							// flags only
							decoded.op = minorOp;
						end
						cpuPkg::aluMov: begin
							decoded.op = minorOp;
							decoded.readRegA = inst[3:0];
							decoded.regWrite = 1'b1;
						end
						default: begin
							// unknown minor stays a no-op
						end
					endcase
				end
				cpuPkg::majAddi, cpuPkg::majAddci, cpuPkg::majSubi, cpuPkg::majCmpi: begin
					// signed immediates
					decoded.imm = signImm;
					decoded.selectImm = 1'b1;
					decoded.regWrite = (major != cpuPkg::majCmpi);
					case (major)
						cpuPkg::majAddi: decoded.op = cpuPkg::aluAdd;
						cpuPkg::majAddci: decoded.op = cpuPkg::aluAddc;
						cpuPkg::majSubi: decoded.op = cpuPkg::aluSub;
						default: decoded.op = cpuPkg::aluCmp;
					endcase
				end
				cpuPkg::majAddui, cpuPkg::majAddcui, cpuPkg::majCmpui, cpuPkg::majMovi: begin
					// unsigned immediates
					decoded.imm = zeroImm;
					decoded.selectImm = 1'b1;
					decoded.regWrite = (major != cpuPkg::majCmpui);
					case (major)
						cpuPkg::majAddui: decoded.op = cpuPkg::aluAddu;
						cpuPkg::majAddcui: decoded.op = cpuPkg::aluAddcu;
						cpuPkg::majCmpui: decoded.op = cpuPkg::aluCmp;
						default: decoded.op = cpuPkg::aluMovi;
					endcase
				end
				cpuPkg::majLui: begin
					decoded.op = cpuPkg::aluLui;
					decoded.imm = {inst[7:0], 8'h00};
					decoded.selectImm = 1'b1;
					decoded.regWrite = 1'b1;
				end
				cpuPkg::majShift: begin
					if (inst[7:4] == lshiMinor || inst[7:4] == rshiMinor) begin
						// shift amount from bits 3..0
						decoded.op = (inst[7:4] == lshiMinor) ? cpuPkg::aluLsh : cpuPkg::aluRsh;
						decoded.imm = {12'h000, inst[3:0]};
						decoded.selectImm = 1'b1;
						decoded.regWrite = 1'b1;
					end else if (minorOp inside {cpuPkg::aluLsh, cpuPkg::aluRsh,
							cpuPkg::aluAlsh, cpuPkg::aluArsh}) begin
						decoded.op = minorOp;
						decoded.regWrite = 1'b1;
					end
				end
				cpuPkg::majMem: begin
					if (inst[7:4] == loadMinor) begin
						// rDest <= mem[inst[3:0]]
						decoded.selectResult = 1'b1;
						decoded.regWrite = 1'b1;
					end else if (inst[7:4] == storMinor) begin
						// mem[inst[11:8]] <= rSrc
						decoded.memAddr = inst[11:8];
						decoded.readRegA = inst[3:0];
						decoded.storeWe = 1'b1;
					end
					// jcond and the rest fall out as no-ops
				end
				default: begin
					// unassigned majors stay no-ops
				end
			endcase
		end
		// top bits 01 and 10 are illegal
	end

endmodule

`default_nettype wire

// ==== hdl/instFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instFetch #(
	parameter int progDepth = 64
) (
	input wire clk,
	input wire reset,
	input wire run,
	input wire progWe,
	input wire [$clog2(progDepth)-1:0] progAddr,
	input wire [17:0] progData,
	output cpuPkg::fetchT fetched
);

	localparam int addrWidth = $clog2(progDepth);

	logic [17:0] progMem [progDepth];
	logic [addrWidth-1:0] pc;
	logic [17:0] instReg;
	logic validReg;

	// program store, filled from outside while stopped
	always_ff @(posedge clk) begin
		if (progWe) begin
			progMem[progAddr] <= progData;
		end
	end

	// counter advances one word per running cycle
	// wraps at the end of the store
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			validReg <= 1'b0;
		end else if (run) begin
			pc <= (pc == addrWidth'(progDepth - 1)) ? '0 : pc + 1'b1;
			validReg <= 1'b1;
		end else begin
			// stopped, counter holds
			validReg <= 1'b0;
		end
	end

	// instruction register between fetch and execute
	always_ff @(posedge clk) begin
		if (run) begin
			instReg <= progMem[pc];
		end
	end

	assign fetched = '{valid: validReg, inst: instReg};

	// loading and running never overlap
	assert property (@(posedge clk) disable iff (reset) !(progWe && run))
		else $error("program store written while running");

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire clk,
	input wire reset,
	input wire writeEn,
	input wire [3:0] writeReg,
	input wire [15:0] writeData,
	input wire [3:0] readRegA,
	input wire [3:0] readRegB,
	output logic [15:0] readDataA,
	output logic [15:0] readDataB
);

	logic [15:0] regs [16];

	// single write port, all registers clear on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeReg] <= writeData;
		end
	end

	// reads are combinational
	// a write lands at the edge, so same-cycle reads see the old value
	assign readDataA = regs[readRegA];
	assign readDataB = regs[readRegB];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module cpuTb -o cpuTbSim \
	> build.log 2>&1 &&
	./obj_dir/cpuTbSim > sim.log 2>&1 ||
	echo "build or simulation ended with an error, see build.log and sim.log"
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam int progDepth = 64;
	localparam int addrWidth = $clog2(progDepth);
	// six tests of reset, load and run take well under 100 cycles each
	localparam int timeoutCycles = 2000;

	typedef enum logic [1:0] {expNone, expWb, expStore} expKindE;

	// what one instruction should retire as
	typedef struct packed {
		expKindE kind;
		logic [3:0] dst;
		logic [15:0] data;
	} expectT;

	// dut outputs seen in one cycle
	typedef struct packed {
		logic wbValid;
		logic [3:0] wbReg;
		logic [15:0] wbData;
		logic storeWe;
		logic [3:0] storeAddr;
		logic [15:0] storeData;
		cpuPkg::flagsT flags;
	} sampleT;

	logic clk;
	logic reset;
	logic run;
	logic progWe;
	logic [addrWidth-1:0] progAddr;
	logic [17:0] progData;
	logic wbValid;
	logic [3:0] wbReg;
	logic [15:0] wbData;
	logic storeWe;
	logic [3:0] storeAddr;
	logic [15:0] storeData;
	cpuPkg::flagsT flags;

	logic [17:0] prog [$];
	expectT expected [$];
	sampleT samples [$];
	int cycles = 0;
	int testErrors = 0;
	int totalErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;

	cpuTop #(.progDepth(progDepth)) dut0 (
		.clk(clk), .reset(reset), .run(run), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeWe(storeWe), .storeAddr(storeAddr), .storeData(storeData), .flags(flags)
	);

	always #10 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeoutCycles) begin
			$display("timeout after %0d cycles, the tests did not complete", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding and expected values
	////////////////////////////////////////////////////////////////////////////

	// r-type and register shift words take {major, minor} from the op code
	function automatic logic [17:0] regWord(cpuPkg::aluOpE op, logic [3:0] rd, logic [3:0] rs);
		logic [7:0] code;
		code = op;
		return {2'b00, code[7:4], rd, code[3:0], rs};
	endfunction

	function automatic logic [17:0] immWord(cpuPkg::majorE major, logic [3:0] rd,
			logic [7:0] imm);
		return {2'b00, major, rd, imm};
	endfunction

	// full 16-bit load keeps the dest in value bits 11..8
	function automatic logic [15:0] fullValue(logic [3:0] rd);
		logic [15:0] rnd;
		rnd = 16'($urandom);
		return {rnd[15:12], rd, rnd[7:0]};
	endfunction

	function automatic cpuPkg::flagsT flagsOf(logic carry, logic [15:0] res);
		return {carry, res == 16'h0000, res[15]};
	endfunction

	task automatic addInst(logic [17:0] word, expKindE kind, logic [3:0] dst, logic [15:0] data);
		expectT e;
		e.kind = kind;
		e.dst = dst;
		e.data = data;
		prog.push_back(word);
		expected.push_back(e);
	endtask

	task automatic addLoad(logic [3:0] rd, logic [15:0] value);
		addInst({2'b11, value}, expWb, rd, value);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reset, program load, run and compare
	////////////////////////////////////////////////////////////////////////////

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b1;
		run = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			@(negedge clk);
			progWe = 1'b1;
			progAddr = addrWidth'(i);
			progData = prog[i];
		end
		@(negedge clk);
		progWe = 1'b0;
	endtask

	// one sample per instruction plus the idle cycle after run drops
	task automatic runProgram(int count);
		sampleT s;
		samples.delete();
		run = 1'b1;
		for (int i = 0; i <= count; i++) begin
			@(negedge clk);
			s = {wbValid, wbReg, wbData, storeWe, storeAddr, storeData, flags};
			samples.push_back(s);
			if (i == count - 1) begin
				run = 1'b0;
			end
		end
	endtask

	task automatic reportMismatch(string name, int idx, logic [15:0] got, logic [15:0] want);
		$display("ERROR %s at instruction %0d: got 0x%h, expected 0x%h", name, idx, got, want);
		testErrors++;
	endtask

	// both strobes low when nothing may retire
	task automatic checkQuiet(string when, logic wbSeen, logic storeSeen);
		if (wbSeen !== 1'b0) begin
			$display("ERROR wbValid %s: got 0x%h, expected 0x0", when, wbSeen);
			testErrors++;
		end
		if (storeSeen !== 1'b0) begin
			$display("ERROR storeWe %s: got 0x%h, expected 0x0", when, storeSeen);
			testErrors++;
		end
	endtask

	task automatic compareEvents(int count);
		for (int i = 0; i < count; i++) begin
			if (samples[i].wbValid !== (expected[i].kind == expWb)) begin
				reportMismatch("wbValid", i, 16'(samples[i].wbValid),
					16'(expected[i].kind == expWb));
			end
			if (samples[i].storeWe !== (expected[i].kind == expStore)) begin
				reportMismatch("storeWe", i, 16'(samples[i].storeWe),
					16'(expected[i].kind == expStore));
			end
			if (expected[i].kind == expWb && samples[i].wbReg !== expected[i].dst) begin
				reportMismatch("wbReg", i, 16'(samples[i].wbReg), 16'(expected[i].dst));
			end
			if (expected[i].kind == expWb && samples[i].wbData !== expected[i].data) begin
				reportMismatch("wbData", i, samples[i].wbData, expected[i].data);
			end
			if (expected[i].kind == expStore && samples[i].storeAddr !== expected[i].dst) begin
				reportMismatch("storeAddr", i, 16'(samples[i].storeAddr), 16'(expected[i].dst));
			end
			if (expected[i].kind == expStore && samples[i].storeData !== expected[i].data) begin
				reportMismatch("storeData", i, samples[i].storeData, expected[i].data);
			end
		end
		checkQuiet("after run dropped", samples[count].wbValid, samples[count].storeWe);
	endtask

	task automatic execute(int count);
		applyReset();
		loadProgram();
		runProgram(count);
		compareEvents(count);
	endtask

	// flags written by instruction idx show one cycle later
	task automatic checkFlags(int idx, cpuPkg::flagsT want);
		if (samples[idx + 1].flags !== want) begin
			reportMismatch("flags", idx, {13'h0000, samples[idx + 1].flags}, {13'h0000, want});
		end
	endtask

	task automatic startTest();
		prog.delete();
		expected.delete();
		testErrors = 0;
	endtask

	task automatic finishTest(string name);
		testsRun++;
		totalErrors += testErrors;
		if (testErrors == 0) begin
			$display("test %s passed", name);
		end else begin
			testsFailed++;
			$display("test %s failed with %0d errors", name, testErrors);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic arithTest();
		logic [15:0] a;
		logic [15:0] b;
		startTest();
		a = fullValue(4'd1);
		b = fullValue(4'd2);
		addLoad(4'd1, a);
		addLoad(4'd2, b);
		// copy r1 first since each op overwrites its own dest
		addInst(regWord(cpuPkg::aluMov, 4'd3, 4'd1), expWb, 4'd3, a);
		addInst(regWord(cpuPkg::aluAdd, 4'd3, 4'd2), expWb, 4'd3, a + b);
		addInst(regWord(cpuPkg::aluMov, 4'd4, 4'd1), expWb, 4'd4, a);
		addInst(regWord(cpuPkg::aluSub, 4'd4, 4'd2), expWb, 4'd4, a - b);
		addInst(regWord(cpuPkg::aluMov, 4'd5, 4'd1), expWb, 4'd5, a);
		addInst(regWord(cpuPkg::aluAnd, 4'd5, 4'd2), expWb, 4'd5, a & b);
		addInst(regWord(cpuPkg::aluMov, 4'd6, 4'd1), expWb, 4'd6, a);
		addInst(regWord(cpuPkg::aluOr, 4'd6, 4'd2), expWb, 4'd6, a | b);
		addInst(regWord(cpuPkg::aluMov, 4'd7, 4'd1), expWb, 4'd7, a);
		addInst(regWord(cpuPkg::aluXor, 4'd7, 4'd2), expWb, 4'd7, a ^ b);
		addInst(regWord(cpuPkg::aluNot, 4'd8, 4'd2), expWb, 4'd8, ~b);
		execute(prog.size());
		finishTest("arith");
	endtask

	task automatic immediateTest();
		logic [15:0] a;
		logic [7:0] nb;
		logic [7:0] c;
		startTest();
		a = fullValue(4'd1);
		// negative byte so sign and zero extension differ
		nb = 8'h80 | 8'($urandom);
		c = 8'($urandom);
		addLoad(4'd1, a);
		addInst(regWord(cpuPkg::aluMov, 4'd2, 4'd1), expWb, 4'd2, a);
		addInst(immWord(cpuPkg::majAddi, 4'd2, nb), expWb, 4'd2, a + {8'hff, nb});
		addInst(immWord(cpuPkg::majAddui, 4'd3, nb), expWb, 4'd3, {8'h00, nb});
		addInst(immWord(cpuPkg::majCmpui, 4'd1, nb), expNone, 4'd0, 16'h0000);
		addInst(immWord(cpuPkg::majMovi, 4'd4, nb), expWb, 4'd4, {8'h00, nb});
		addInst(immWord(cpuPkg::majLui, 4'd5, c), expWb, 4'd5, {c, 8'h00});
		execute(prog.size());
		checkFlags(4, flagsOf(a < {8'h00, nb}, a - {8'h00, nb}));
		finishTest("immediate");
	endtask

	task automatic shiftTest();
		logic [15:0] a;
		logic [15:0] s;
		logic [3:0] k;
		logic [3:0] m;
		startTest();
		// top bit set so arithmetic shift fills ones
		a = fullValue(4'd1) | 16'h8000;
		s = fullValue(4'd2);
		k = 4'($urandom);
		m = 4'($urandom);
		addLoad(4'd1, a);
		addLoad(4'd2, s);
		addInst(regWord(cpuPkg::aluMov, 4'd3, 4'd1), expWb, 4'd3, a);
		addInst(regWord(cpuPkg::aluLsh, 4'd3, 4'd2), expWb, 4'd3, a << s[3:0]);
		addInst(regWord(cpuPkg::aluMov, 4'd4, 4'd1), expWb, 4'd4, a);
		addInst(regWord(cpuPkg::aluRsh, 4'd4, 4'd2), expWb, 4'd4, a >> s[3:0]);
		addInst(regWord(cpuPkg::aluMov, 4'd5, 4'd1), expWb, 4'd5, a);
		addInst(regWord(cpuPkg::aluArsh, 4'd5, 4'd2), expWb, 4'd5,
			(a >> s[3:0]) | ~(16'hffff >> s[3:0]));
		// immediate forms use minor 0 for left and minor 1 for right
		addInst(regWord(cpuPkg::aluMov, 4'd6, 4'd1), expWb, 4'd6, a);
		addInst(immWord(cpuPkg::majShift, 4'd6, {4'h0, k}), expWb, 4'd6, a << k);
		addInst(regWord(cpuPkg::aluMov, 4'd7, 4'd1), expWb, 4'd7, a);
		addInst(immWord(cpuPkg::majShift, 4'd7, {4'h1, m}), expWb, 4'd7, a >> m);
		execute(prog.size());
		finishTest("shifts");
	endtask

	task automatic memoryTest();
		logic [15:0] a;
		logic [15:0] b;
		startTest();
		a = fullValue(4'd1);
		b = fullValue(4'd2);
		addLoad(4'd1, a);
		addLoad(4'd2, b);
		// stor takes the address from bits 11..8 and the source from 3..0
		addInst(immWord(cpuPkg::majMem, 4'd5, 8'h41), expStore, 4'd5, a);
		addInst(immWord(cpuPkg::majMem, 4'd9, 8'h42), expStore, 4'd9, b);
		addInst(immWord(cpuPkg::majMem, 4'd3, 8'h05), expWb, 4'd3, a);
		addInst(immWord(cpuPkg::majMem, 4'd4, 8'h09), expWb, 4'd4, b);
		// untouched word still holds its reset value
		addInst(immWord(cpuPkg::majMem, 4'd6, 8'h02), expWb, 4'd6, 16'h0000);
		execute(prog.size());
		finishTest("memory");
	endtask

	task automatic flagsTest();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] xl;
		logic [15:0] xh;
		logic [15:0] yl;
		logic [15:0] yh;
		logic [32:0] sum;
		startTest();
		a = fullValue(4'd1);
		b = fullValue(4'd2);
		// low halves both negative so the low add always carries
		xl = fullValue(4'd4) | 16'h8000;
		xh = fullValue(4'd5);
		yl = fullValue(4'd6) | 16'h8000;
		yh = fullValue(4'd7);
		sum = {1'b0, xh, xl} + {1'b0, yh, yl};
		addLoad(4'd1, a);
		addLoad(4'd2, b);
		addInst(regWord(cpuPkg::aluCmp, 4'd1, 4'd2), expNone, 4'd0, 16'h0000);
		addInst(regWord(cpuPkg::aluCmp, 4'd1, 4'd1), expNone, 4'd0, 16'h0000);
		addLoad(4'd4, xl);
		addLoad(4'd5, xh);
		addLoad(4'd6, yl);
		addLoad(4'd7, yh);
		addInst(regWord(cpuPkg::aluAdd, 4'd4, 4'd6), expWb, 4'd4, sum[15:0]);
		addInst(regWord(cpuPkg::aluAddc, 4'd5, 4'd7), expWb, 4'd5, sum[31:16]);
		execute(prog.size());
		checkFlags(2, flagsOf(a < b, a - b));
		checkFlags(3, flagsOf(1'b0, 16'h0000));
		// loads leave the cmp flags in place
		checkFlags(7, flagsOf(1'b0, 16'h0000));
		checkFlags(9, flagsOf(sum[32], sum[31:16]));
		finishTest("flags");
	endtask

	task automatic noOpTest();
		logic [15:0] a;
		startTest();
		a = fullValue(4'd1);
		addLoad(4'd1, a);
		// top bits 01 and 10
		addInst({2'b01, 16'($urandom)}, expNone, 4'd0, 16'h0000);
		addInst({2'b10, 16'($urandom)}, expNone, 4'd0, 16'h0000);
		// jcond then an unassigned r-type minor
		addInst(immWord(cpuPkg::majMem, 4'd2, 8'hc1), expNone, 4'd0, 16'h0000);
		addInst({2'b00, 4'h0, 4'd3, 4'h0, 4'd1}, expNone, 4'd0, 16'h0000);
		addInst(regWord(cpuPkg::aluMov, 4'd2, 4'd1), expWb, 4'd2, a);
		// loaded but never fetched
		addLoad(4'd3, fullValue(4'd3));
		addLoad(4'd4, fullValue(4'd4));
		execute(6);
		repeat (4) begin
			@(negedge clk);
			checkQuiet("while run is low", wbValid, storeWe);
		end
		// reset wins over a raised run
		reset = 1'b1;
		run = 1'b1;
		repeat (3) begin
			@(negedge clk);
			checkQuiet("during reset", wbValid, storeWe);
		end
		// counter restarts at word 0 once reset drops
		reset = 1'b0;
		@(negedge clk);
		if (wbValid !== 1'b1) begin
			reportMismatch("wbValid", 0, 16'(wbValid), 16'h0001);
		end
		if (wbReg !== 4'd1) begin
			reportMismatch("wbReg", 0, 16'(wbReg), 16'h0001);
		end
		if (wbData !== a) begin
			reportMismatch("wbData", 0, wbData, a);
		end
		run = 1'b0;
		@(negedge clk);
		checkQuiet("after run dropped", wbValid, storeWe);
		finishTest("noops");
	endtask

	initial begin
		void'($urandom(42843));
		clk = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		arithTest();
		immediateTest();
		shiftTest();
		memoryTest();
		flagsTest();
		noOpTest();
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrors);
		if (totalErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
